/* common/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Station depth for the FX0 pipe
`define RV_FX0_ENTRIES 4

`define ITAG_SIZE_ENC 7
`define GPR_POOL_ENC 6

// Completion busses watched by waiting sources (fx0 and lq)
`define NUM_WAKE_BUSSES 2

`define INSTR_WIDTH 32

`endif

/* common/rv_pkg.sv */
`default_nettype none
`include "rv_consts.svh"

package rv_pkg;

   typedef logic [0:`ITAG_SIZE_ENC-1] itag_t;
   typedef logic [0:`GPR_POOL_ENC-1]  preg_t;
   typedef logic [0:`INSTR_WIDTH-1]   instr_t;

   // One source operand, dep stays set until its producer completes
   typedef struct packed {
      logic  v;
      preg_t p;
      logic  dep;
      itag_t itag;
   } src_t;

   typedef struct packed {
      itag_t  itag;
      instr_t instr;
      logic   t1_v;
      preg_t  t1_p;
      src_t   s1;
      src_t   s2;
   } rv_instr_t;

   typedef enum logic [1:0] {
      ENTRY_EMPTY,
      ENTRY_WAIT,
      ENTRY_READY
   } entry_state_t;

   typedef logic [0:$clog2(`RV_FX0_ENTRIES)-1] entry_idx_t;

endpackage

`default_nettype wire

/* common/rv_issue_if.sv */
`default_nettype none

// Issued record on its way from the rv1 register to ex0
interface rv_issue_if;
   import rv_pkg::*;

   logic      vld;
   rv_instr_t rec;

   modport issue_src (
      output vld,
      output rec
   );

   modport issue_dst (
      input vld,
      input rec
   );

endinterface

`default_nettype wire

/* rv_station/rv_entry_queue.sv */
`default_nettype none
`include "rv_consts.svh"

module rv_entry_queue (
   input  logic                        nclk,
   input  logic                        reset,
   input  logic                        rv0_instr_vld,
   input  rv_pkg::rv_instr_t           rv0_instr,
   input  logic [0:`NUM_WAKE_BUSSES-1] wake_vld,
   input  rv_pkg::itag_t               wake_itag [0:`NUM_WAKE_BUSSES-1],
   input  logic                        cp_flush,
   input  logic [0:`RV_FX0_ENTRIES-1]  issue_onehot,
   output logic [0:`RV_FX0_ENTRIES-1]  alloc_onehot,
   output logic [0:`RV_FX0_ENTRIES-1]  entry_ready,
   output rv_pkg::rv_instr_t           entries [0:`RV_FX0_ENTRIES-1]
);
   import rv_pkg::*;

   entry_state_t               state_q [0:`RV_FX0_ENTRIES-1];
   rv_instr_t                  rec_q   [0:`RV_FX0_ENTRIES-1];
   rv_instr_t                  rec_nxt [0:`RV_FX0_ENTRIES-1];
   logic [0:`RV_FX0_ENTRIES-1] ready_nxt;

   // Clears dep when any valid completion bus carries the awaited itag
   function automatic src_t wake_src(
      input src_t                        s,
      input logic [0:`NUM_WAKE_BUSSES-1] vld,
      input itag_t                       itag [0:`NUM_WAKE_BUSSES-1]
   );
      src_t r;
      r = s;
      for (int b = 0; b < `NUM_WAKE_BUSSES; b++) begin
         if (vld[b] && (itag[b] == s.itag)) begin
            r.dep = 1'b0;
         end
      end
      return r;
   endfunction

   // Lowest empty entry takes the dispatch, credits guarantee one exists
   always_comb begin
      alloc_onehot = '0;
      for (int i = `RV_FX0_ENTRIES - 1; i >= 0; i--) begin
         if (state_q[i] == ENTRY_EMPTY) begin
            alloc_onehot    = '0;
            alloc_onehot[i] = rv0_instr_vld;
         end
      end
   end

   // A wakeup on the dispatch cycle is applied to the incoming record too
   always_comb begin
      for (int i = 0; i < `RV_FX0_ENTRIES; i++) begin
         rec_nxt[i]    = alloc_onehot[i] ? rv0_instr : rec_q[i];
         rec_nxt[i].s1 = wake_src(rec_nxt[i].s1, wake_vld, wake_itag);
         rec_nxt[i].s2 = wake_src(rec_nxt[i].s2, wake_vld, wake_itag);
         ready_nxt[i]  = !rec_nxt[i].s1.dep && !rec_nxt[i].s2.dep;
      end
   end

   // Flush wins over a dispatch in the same cycle
   always_ff @(posedge nclk) begin
      for (int i = 0; i < `RV_FX0_ENTRIES; i++) begin
         if (reset || cp_flush) begin
            state_q[i] <= ENTRY_EMPTY;
         end else if (alloc_onehot[i]) begin
            state_q[i] <= ready_nxt[i] ? ENTRY_READY : ENTRY_WAIT;
         end else if (issue_onehot[i]) begin
            state_q[i] <= ENTRY_EMPTY;
         end else if ((state_q[i] == ENTRY_WAIT) && ready_nxt[i]) begin
            state_q[i] <= ENTRY_READY;
         end
      end
   end

   always_ff @(posedge nclk) begin
      for (int i = 0; i < `RV_FX0_ENTRIES; i++) begin
         if (alloc_onehot[i] || (state_q[i] == ENTRY_WAIT)) begin
            rec_q[i] <= rec_nxt[i];
         end
      end
   end

   always_comb begin
      for (int i = 0; i < `RV_FX0_ENTRIES; i++) begin
         entry_ready[i] = (state_q[i] == ENTRY_READY);
      end
   end

   assign entries = rec_q;

endmodule

`default_nettype wire

/* rv_station/rv_issue_select.sv */
`default_nettype none
`include "rv_consts.svh"

module rv_issue_select (
   input  logic                       nclk,
   input  logic                       reset,
   input  logic [0:`RV_FX0_ENTRIES-1] alloc_onehot,
   input  logic [0:`RV_FX0_ENTRIES-1] entry_ready,
   input  rv_pkg::rv_instr_t          entries [0:`RV_FX0_ENTRIES-1],
   input  logic                       fx0_rv_hold_all,
   input  logic                       cp_flush,
   output logic [0:`RV_FX0_ENTRIES-1] issue_onehot,
   output logic                       credit_free,
   rv_issue_if.issue_src              iss
);
   import rv_pkg::*;

   // Row i holds the entries that are older than entry i
   logic [0:`RV_FX0_ENTRIES-1] older_q [0:`RV_FX0_ENTRIES-1];
   logic [0:`RV_FX0_ENTRIES-1] oldest;
   entry_idx_t                 pick_idx;
   logic                       pick_vld;
   logic                       rv1_vld_q;
   rv_instr_t                  rv1_rec_q;

   // A new entry is younger than everyone, and its column is cleared
   // so stale bits left by earlier occupants never count
   always_ff @(posedge nclk) begin
      for (int i = 0; i < `RV_FX0_ENTRIES; i++) begin
         if (reset) begin
            older_q[i] <= '0;
         end else if (alloc_onehot[i]) begin
            older_q[i] <= ~alloc_onehot;
         end else begin
            older_q[i] <= older_q[i] & ~alloc_onehot;
         end
      end
   end

   always_comb begin
      for (int i = 0; i < `RV_FX0_ENTRIES; i++) begin
         oldest[i] = entry_ready[i] && !(|(older_q[i] & entry_ready));
      end
   end

   always_comb begin
      pick_idx = '0;
      for (int i = `RV_FX0_ENTRIES - 1; i >= 0; i--) begin
         if (oldest[i]) begin
            pick_idx = entry_idx_t'(i);
         end
      end
   end

   assign pick_vld     = (|oldest) && !fx0_rv_hold_all && !cp_flush;
   assign issue_onehot = pick_vld ? oldest : '0;

   always_ff @(posedge nclk) begin
      if (reset) begin
         rv1_vld_q <= 1'b0;
      end else begin
         rv1_vld_q <= pick_vld;
      end
   end

   always_ff @(posedge nclk) begin
      if (pick_vld) begin
         rv1_rec_q <= entries[pick_idx];
      end
   end

   assign iss.vld     = rv1_vld_q;
   assign iss.rec     = rv1_rec_q;
   // One credit goes back for every issued entry
   assign credit_free = rv1_vld_q;

endmodule

`default_nettype wire

/* rtl/rv_ex0_stage.sv */
`default_nettype none

module rv_ex0_stage (
   input  logic           nclk,
   input  logic           reset,
   rv_issue_if.issue_dst  iss,
   output rv_pkg::itag_t  ex0_itag,
   output rv_pkg::instr_t ex0_instr,
   output logic           ex0_t1_v,
   output rv_pkg::preg_t  ex0_t1_p
);
   import rv_pkg::*;

   itag_t  ex0_itag_q;
   instr_t ex0_instr_q;
   logic   ex0_t1_v_q;
   preg_t  ex0_t1_p_q;

   // Registers only load on a valid issue and hold otherwise
   always_ff @(posedge nclk) begin
      if (reset) begin
         ex0_itag_q  <= '0;
         ex0_instr_q <= '0;
         ex0_t1_v_q  <= 1'b0;
         ex0_t1_p_q  <= '0;
      end else if (iss.vld) begin
         ex0_itag_q  <= iss.rec.itag;
         ex0_instr_q <= iss.rec.instr;
         ex0_t1_v_q  <= iss.rec.t1_v;
         ex0_t1_p_q  <= iss.rec.t1_p;
      end
   end

   assign ex0_itag  = ex0_itag_q;
   assign ex0_instr = ex0_instr_q;
   assign ex0_t1_v  = ex0_t1_v_q;
   assign ex0_t1_p  = ex0_t1_p_q;

endmodule

`default_nettype wire

/* rtl/rv_fx0_rvs.sv */
`default_nettype none
`include "rv_consts.svh"

module rv_fx0_rvs (
   input  logic           nclk,
   input  logic           reset,

   input  logic           rv0_instr_vld,
   input  rv_pkg::itag_t  rv0_instr_itag,
   input  rv_pkg::instr_t rv0_instr_instr,
   input  logic           rv0_instr_t1_v,
   input  rv_pkg::preg_t  rv0_instr_t1_p,
   input  logic           rv0_instr_s1_v,
   input  rv_pkg::preg_t  rv0_instr_s1_p,
   input  logic           rv0_instr_s1_dep_hit,
   input  rv_pkg::itag_t  rv0_instr_s1_itag,
   input  logic           rv0_instr_s2_v,
   input  rv_pkg::preg_t  rv0_instr_s2_p,
   input  logic           rv0_instr_s2_dep_hit,
   input  rv_pkg::itag_t  rv0_instr_s2_itag,

   input  logic           fx0_rv_itag_vld,
   input  rv_pkg::itag_t  fx0_rv_itag,
   input  logic           lq_rv_ext_itag0_vld,
   input  rv_pkg::itag_t  lq_rv_ext_itag0,

   input  logic           cp_flush,
   input  logic           fx0_rv_hold_all,

   output logic           rv_fx0_vld,
   output rv_pkg::itag_t  rv_fx0_itag,
   output logic           rv_fx0_s1_v,
   output rv_pkg::preg_t  rv_fx0_s1_p,
   output logic           rv_fx0_s2_v,
   output rv_pkg::preg_t  rv_fx0_s2_p,

   output rv_pkg::itag_t  rv_fx0_ex0_itag,
   output rv_pkg::instr_t rv_fx0_ex0_instr,
   output logic           rv_fx0_ex0_t1_v,
   output rv_pkg::preg_t  rv_fx0_ex0_t1_p,

   output logic           rv_iu_fx0_credit_free
);
   import rv_pkg::*;

   rv_instr_t                   rv0_instr;
   logic [0:`NUM_WAKE_BUSSES-1] wake_vld;
   itag_t                       wake_itag [0:`NUM_WAKE_BUSSES-1];
   logic [0:`RV_FX0_ENTRIES-1]  alloc_onehot;
   logic [0:`RV_FX0_ENTRIES-1]  entry_ready;
   logic [0:`RV_FX0_ENTRIES-1]  issue_onehot;
   rv_instr_t                   entries [0:`RV_FX0_ENTRIES-1];

   rv_issue_if iss ();

   assign rv0_instr.itag  = rv0_instr_itag;
   assign rv0_instr.instr = rv0_instr_instr;
   assign rv0_instr.t1_v  = rv0_instr_t1_v;
   assign rv0_instr.t1_p  = rv0_instr_t1_p;
   assign rv0_instr.s1    = '{v: rv0_instr_s1_v, p: rv0_instr_s1_p,
                              dep: rv0_instr_s1_dep_hit, itag: rv0_instr_s1_itag};
   assign rv0_instr.s2    = '{v: rv0_instr_s2_v, p: rv0_instr_s2_p,
                              dep: rv0_instr_s2_dep_hit, itag: rv0_instr_s2_itag};

   // Bus 0 is the fx0 completion, bus 1 the lq completion
   assign wake_vld     = {fx0_rv_itag_vld, lq_rv_ext_itag0_vld};
   assign wake_itag[0] = fx0_rv_itag;
   assign wake_itag[1] = lq_rv_ext_itag0;

   rv_entry_queue queue (
      .nclk          (nclk),
      .reset         (reset),
      .rv0_instr_vld (rv0_instr_vld),
      .rv0_instr     (rv0_instr),
      .wake_vld      (wake_vld),
      .wake_itag     (wake_itag),
      .cp_flush      (cp_flush),
      .issue_onehot  (issue_onehot),
      .alloc_onehot  (alloc_onehot),
      .entry_ready   (entry_ready),
      .entries       (entries)
   );

   rv_issue_select select (
      .nclk            (nclk),
      .reset           (reset),
      .alloc_onehot    (alloc_onehot),
      .entry_ready     (entry_ready),
      .entries         (entries),
      .fx0_rv_hold_all (fx0_rv_hold_all),
      .cp_flush        (cp_flush),
      .issue_onehot    (issue_onehot),
      .credit_free     (rv_iu_fx0_credit_free),
      .iss             (iss.issue_src)
   );

   rv_ex0_stage ex0 (
      .nclk      (nclk),
      .reset     (reset),
      .iss       (iss.issue_dst),
      .ex0_itag  (rv_fx0_ex0_itag),
      .ex0_instr (rv_fx0_ex0_instr),
      .ex0_t1_v  (rv_fx0_ex0_t1_v),
      .ex0_t1_p  (rv_fx0_ex0_t1_p)
   );

   assign rv_fx0_vld  = iss.vld;
   assign rv_fx0_itag = iss.rec.itag;
   assign rv_fx0_s1_v = iss.rec.s1.v;
   assign rv_fx0_s1_p = iss.rec.s1.p;
   assign rv_fx0_s2_v = iss.rec.s2.v;
   assign rv_fx0_s2_p = iss.rec.s2.p;

endmodule

`default_nettype wire

/* tb/rv_fx0_rvs_sva.sv */
`default_nettype none

module rv_fx0_rvs_sva (
   input logic nclk,
   input logic reset,
   input logic rv0_instr_vld,
   input logic rv_fx0_vld,
   input logic rv_iu_fx0_credit_free,
   input logic fx0_rv_hold_all,
   input logic cp_flush
);
   timeunit 1ns;
   timeprecision 1ps;

   // Dispatched entries whose credit has not come back yet
   int outstanding_q;

   always_ff @(posedge nclk) begin
      if (reset || cp_flush) begin
         outstanding_q <= 0;
      end else begin
         outstanding_q <= outstanding_q + int'(rv0_instr_vld) - int'(rv_iu_fx0_credit_free);
      end
   end

   // A credit only ever returns an entry that dispatch actually filled
   credit_needs_dispatch: assert property (@(posedge nclk) disable iff (reset)
      rv_iu_fx0_credit_free |-> (outstanding_q > 0))
      else $error("credit_free without an outstanding dispatched entry");

   no_issue_after_hold: assert property (@(posedge nclk) disable iff (reset)
      fx0_rv_hold_all |=> !rv_fx0_vld)
      else $error("issue in the cycle after a held edge");

   no_issue_after_flush: assert property (@(posedge nclk) disable iff (reset)
      cp_flush |=> !rv_fx0_vld)
      else $error("issue in the cycle after a flush edge");

endmodule

`default_nettype wire

/* tb/tb_rv_fx0_rvs.sv */
`default_nettype none
`include "rv_consts.svh"

module tb_rv_fx0_rvs;
   timeunit 1ns;
   timeprecision 1ps;
   import rv_pkg::*;

   localparam int RAND_CYCLES = 400;
   // Reset and the directed tests stay under 100 cycles and the final drain under 100
   localparam int MAX_CYCLES  = 10 + 100 + RAND_CYCLES + 100;

   logic        nclk;
   logic        reset;
   logic        rv0_instr_vld;
   rv_instr_t   drv;
   logic [0:1]  wk_vld;
   itag_t       wk_itag [0:1];
   logic        cp_flush;
   logic        fx0_rv_hold_all;
   logic        rv_fx0_vld;
   itag_t       rv_fx0_itag;
   logic        rv_fx0_s1_v;
   preg_t       rv_fx0_s1_p;
   logic        rv_fx0_s2_v;
   preg_t       rv_fx0_s2_p;
   itag_t       ex0_itag;
   instr_t      ex0_instr;
   logic        ex0_t1_v;
   preg_t       ex0_t1_p;
   logic        credit_free;

   // Reference model keeps the station entries in dispatch order
   rv_instr_t   model_q [$];
   bit          model_rdy [$];
   logic        exp_vld;
   rv_instr_t   exp_rec;
   rv_instr_t   exp_ex0;
   int          credits;
   int          errors;
   int          cycles = 0;
   logic [31:0] lfsr;
   itag_t       next_itag;
   string       test_name;

   rv_fx0_rvs uut (
      .nclk                 (nclk),
      .reset                (reset),
      .rv0_instr_vld        (rv0_instr_vld),
      .rv0_instr_itag       (drv.itag),
      .rv0_instr_instr      (drv.instr),
      .rv0_instr_t1_v       (drv.t1_v),
      .rv0_instr_t1_p       (drv.t1_p),
      .rv0_instr_s1_v       (drv.s1.v),
      .rv0_instr_s1_p       (drv.s1.p),
      .rv0_instr_s1_dep_hit (drv.s1.dep),
      .rv0_instr_s1_itag    (drv.s1.itag),
      .rv0_instr_s2_v       (drv.s2.v),
      .rv0_instr_s2_p       (drv.s2.p),
      .rv0_instr_s2_dep_hit (drv.s2.dep),
      .rv0_instr_s2_itag    (drv.s2.itag),
      .fx0_rv_itag_vld      (wk_vld[0]),
      .fx0_rv_itag          (wk_itag[0]),
      .lq_rv_ext_itag0_vld  (wk_vld[1]),
      .lq_rv_ext_itag0      (wk_itag[1]),
      .cp_flush             (cp_flush),
      .fx0_rv_hold_all      (fx0_rv_hold_all),
      .rv_fx0_vld           (rv_fx0_vld),
      .rv_fx0_itag          (rv_fx0_itag),
      .rv_fx0_s1_v          (rv_fx0_s1_v),
      .rv_fx0_s1_p          (rv_fx0_s1_p),
      .rv_fx0_s2_v          (rv_fx0_s2_v),
      .rv_fx0_s2_p          (rv_fx0_s2_p),
      .rv_fx0_ex0_itag      (ex0_itag),
      .rv_fx0_ex0_instr     (ex0_instr),
      .rv_fx0_ex0_t1_v      (ex0_t1_v),
      .rv_fx0_ex0_t1_p      (ex0_t1_p),
      .rv_iu_fx0_credit_free(credit_free)
   );

   bind rv_fx0_rvs rv_fx0_rvs_sva sva (
      .nclk                 (nclk),
      .reset                (reset),
      .rv0_instr_vld        (rv0_instr_vld),
      .rv_fx0_vld           (rv_fx0_vld),
      .rv_iu_fx0_credit_free(rv_iu_fx0_credit_free),
      .fx0_rv_hold_all      (fx0_rv_hold_all),
      .cp_flush             (cp_flush)
   );

   initial begin
      nclk = 1'b0;
      forever #50 nclk = ~nclk;
   end

   always @(posedge nclk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // Galois LFSR stepped once for every bit taken
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
      end
      return v;
   endfunction

   // Producers that sources wait on come from a small pool so wakeups hit
   function automatic itag_t wait_itag();
      return itag_t'(32'h70 + random_bits(3));
   endfunction

   function automatic logic woken(input itag_t t);
      return (wk_vld[0] && (wk_itag[0] == t)) || (wk_vld[1] && (wk_itag[1] == t));
   endfunction

   function automatic rv_instr_t after_wakeup(input rv_instr_t r);
      rv_instr_t w;
      w = r;
      if (woken(r.s1.itag)) begin
         w.s1.dep = 1'b0;
      end
      if (woken(r.s2.itag)) begin
         w.s2.dep = 1'b0;
      end
      return w;
   endfunction

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_itag(input string what, input itag_t exp, input itag_t act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_preg(input string what, input preg_t exp, input preg_t act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_instr(input string what, input instr_t exp, input instr_t act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic set_dispatch(input logic d1, input itag_t w1, input logic d2,
                               input itag_t w2);
      drv.itag    = next_itag;
      next_itag   = next_itag + 1'b1;
      drv.instr   = random_bits(32);
      drv.t1_v    = 1'(random_bits(1));
      drv.t1_p    = preg_t'(random_bits(6));
      drv.s1.v    = 1'(random_bits(1));
      drv.s1.p    = preg_t'(random_bits(6));
      drv.s1.dep  = d1;
      drv.s1.itag = w1;
      drv.s2.v    = 1'(random_bits(1));
      drv.s2.p    = preg_t'(random_bits(6));
      drv.s2.dep  = d2;
      drv.s2.itag = w2;
      rv0_instr_vld = 1'b1;
   endtask

   task automatic set_wake(input int bus, input itag_t t);
      wk_vld[bus]  = 1'b1;
      wk_itag[bus] = t;
   endtask

   // What the coming clock edge does to the station
   task automatic model_edge();
      int        pick;
      rv_instr_t r;
      pick = -1;
      if (exp_vld) begin
         exp_ex0 = exp_rec;
      end
      if (!fx0_rv_hold_all && !cp_flush) begin
         for (int i = model_q.size() - 1; i >= 0; i--) begin
            if (model_rdy[i]) begin
               pick = i;
            end
         end
      end
      exp_vld = (pick >= 0);
      if (exp_vld) begin
         exp_rec = model_q[pick];
         model_q.delete(pick);
         model_rdy.delete(pick);
      end
      if (cp_flush) begin
         model_q.delete();
         model_rdy.delete();
         credits = `RV_FX0_ENTRIES;
      end else begin
         for (int i = 0; i < model_q.size(); i++) begin
            model_q[i]   = after_wakeup(model_q[i]);
            model_rdy[i] = !model_q[i].s1.dep && !model_q[i].s2.dep;
         end
         if (rv0_instr_vld) begin
            r = after_wakeup(drv);
            model_q.push_back(r);
            model_rdy.push_back(!r.s1.dep && !r.s2.dep);
            credits--;
         end
      end
   endtask

   task automatic compare_outputs();
      check_bit("rv_fx0_vld", exp_vld, rv_fx0_vld);
      check_bit("credit_free", exp_vld, credit_free);
      if (exp_vld) begin
         check_itag("rv_fx0_itag", exp_rec.itag, rv_fx0_itag);
         check_bit("rv_fx0_s1_v", exp_rec.s1.v, rv_fx0_s1_v);
         check_preg("rv_fx0_s1_p", exp_rec.s1.p, rv_fx0_s1_p);
         check_bit("rv_fx0_s2_v", exp_rec.s2.v, rv_fx0_s2_v);
         check_preg("rv_fx0_s2_p", exp_rec.s2.p, rv_fx0_s2_p);
      end
      check_itag("ex0_itag", exp_ex0.itag, ex0_itag);
      check_instr("ex0_instr", exp_ex0.instr, ex0_instr);
      check_bit("ex0_t1_v", exp_ex0.t1_v, ex0_t1_v);
      check_preg("ex0_t1_p", exp_ex0.t1_p, ex0_t1_p);
   endtask

   task automatic step();
      model_edge();
      @(posedge nclk);
      @(negedge nclk);
      compare_outputs();
      if (credit_free === 1'b1) begin
         credits++;
      end
      rv0_instr_vld = 1'b0;
      wk_vld        = '0;
      cp_flush      = 1'b0;
   endtask

   // Walks the wakeup pool on the fx0 bus until everything has issued
   task automatic drain();
      int n;
      n = 0;
      fx0_rv_hold_all = 1'b0;
      while ((model_q.size() > 0) || exp_vld) begin
         set_wake(0, itag_t'(32'h70 + (n % 8)));
         n++;
         step();
      end
      if (credits != `RV_FX0_ENTRIES) begin
         errors++;
         $display("Test %s ends with %0d credits although the station is empty",
                  test_name, credits);
      end
   endtask

   initial begin
      logic  d1;
      logic  d2;
      itag_t w1;
      itag_t w2;
      lfsr            = 32'h2b98;
      errors          = 0;
      credits         = `RV_FX0_ENTRIES;
      exp_vld         = 1'b0;
      exp_rec         = '0;
      exp_ex0         = '0;
      next_itag       = '0;
      reset           = 1'b1;
      rv0_instr_vld   = 1'b0;
      drv             = '0;
      wk_vld          = '0;
      wk_itag[0]      = '0;
      wk_itag[1]      = '0;
      cp_flush        = 1'b0;
      fx0_rv_hold_all = 1'b0;
      test_name       = "reset";
      repeat (10) @(posedge nclk);
      @(negedge nclk);
      reset = 1'b0;
      compare_outputs();

      test_name = "in_order";
      for (int i = 0; i < 3; i++) begin
         set_dispatch(1'b0, '0, 1'b0, '0);
         step();
      end
      drain();

      // The second entry overtakes the first and the last two wake together
      test_name = "wakeup";
      set_dispatch(1'b1, 7'h71, 1'b0, '0);
      step();
      set_dispatch(1'b0, '0, 1'b0, '0);
      step();
      set_dispatch(1'b0, '0, 1'b1, 7'h72);
      step();
      set_dispatch(1'b1, 7'h73, 1'b0, '0);
      step();
      repeat (3) step();
      set_wake(1, 7'h71);
      step();
      set_wake(0, 7'h72);
      set_wake(1, 7'h73);
      step();
      drain();

      test_name = "hold";
      fx0_rv_hold_all = 1'b1;
      for (int i = 0; i < `RV_FX0_ENTRIES; i++) begin
         set_dispatch(1'b0, '0, 1'b0, '0);
         step();
      end
      repeat (3) step();
      drain();

      test_name = "flush";
      set_dispatch(1'b0, '0, 1'b0, '0);
      step();
      set_dispatch(1'b1, 7'h74, 1'b0, '0);
      step();
      set_dispatch(1'b0, '0, 1'b0, '0);
      step();
      cp_flush = 1'b1;
      step();
      set_wake(0, 7'h74);
      step();
      repeat (2) step();
      for (int i = 0; i < 2; i++) begin
         set_dispatch(1'b0, '0, 1'b0, '0);
         step();
      end
      drain();

      test_name = "random";
      for (int c = 0; c < RAND_CYCLES; c++) begin
         fx0_rv_hold_all = (random_bits(3) == 0);
         cp_flush        = (random_bits(6) == 0);
         if (random_bits(1) != 0) begin
            set_wake(0, wait_itag());
         end
         if (random_bits(1) != 0) begin
            set_wake(1, wait_itag());
         end
         if (!cp_flush && (credits > 0) && (random_bits(2) != 0)) begin
            d1 = 1'(random_bits(1));
            w1 = wait_itag();
            d2 = 1'(random_bits(1));
            w2 = wait_itag();
            set_dispatch(d1, w1, d2, w2);
         end
         step();
      end
      drain();

      $display("Run finished after %0d cycles with %0d errors", cycles, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/rv_pkg.sv
common/rv_issue_if.sv
rv_station/rv_entry_queue.sv
rv_station/rv_issue_select.sv
rtl/rv_ex0_stage.sv
rtl/rv_fx0_rvs.sv
tb/rv_fx0_rvs_sva.sv
tb/tb_rv_fx0_rvs.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_fx0_rvs
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' list.f) common/rv_consts.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): list.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(BUILD_DIR)
